// File: common/dmmu_pkg.sv
/* Widths, APB register map, privilege codes and the APB write word layouts.
   TLB_ENTRIES must be a power of two of at least 2 and at most 32 to fit the map. */
package dmmu_pkg;

  // Address split
  localparam int VADDR_WIDTH       = 32;
  localparam int PAGE_OFFSET_WIDTH = 12;
  localparam int VTAG_WIDTH        = VADDR_WIDTH - PAGE_OFFSET_WIDTH;
  localparam int PTAG_WIDTH        = 20;
  localparam int PADDR_WIDTH       = PTAG_WIDTH + PAGE_OFFSET_WIDTH;

  // Top PTAG bits select the device domain, only domain 0 is reachable
  localparam int DID_WIDTH    = 2;
  localparam int UNCACHED_BIT = 17;

  localparam int TLB_ENTRIES   = 8;
  localparam int TLB_IDX_WIDTH = $clog2(TLB_ENTRIES);

  // Privilege modes, 2 is reserved and treated like M
  localparam logic [1:0] PRIV_U = 2'd0;
  localparam logic [1:0] PRIV_S = 2'd1;
  localparam logic [1:0] PRIV_M = 2'd3;

  // APB
  localparam int APB_ADDR_WIDTH = 8;
  localparam int APB_DATA_WIDTH = 32;

  localparam logic [APB_ADDR_WIDTH-1:0] APB_ADDR_CTRL       = 8'h00;
  localparam logic [APB_ADDR_WIDTH-1:0] APB_ADDR_VTAG       = 8'h04;
  localparam logic [APB_ADDR_WIDTH-1:0] APB_ADDR_FENCE      = 8'h08;
  localparam logic [APB_ADDR_WIDTH-1:0] APB_ADDR_ENTRY_BASE = 8'h40;

  // One word per slot above the entry base
  localparam logic [APB_ADDR_WIDTH-1:0] APB_ENTRY_SPAN =
    APB_ADDR_WIDTH'(4 * TLB_ENTRIES);

  // One APB write word, read as control or as PTE depending on the address
  typedef union packed {
    struct packed {
      logic [APB_DATA_WIDTH-6:0] rsvd;
      logic                      uncached_mode;
      logic                      translation_en;
      logic                      sum;
      logic [1:0]                priv_mode;
    } ctrl;
    struct packed {
      logic [APB_DATA_WIDTH-PTAG_WIDTH-5:0] rsvd;
      logic                                 v;
      logic                                 d;
      logic                                 w;
      logic                                 u;
      logic [PTAG_WIDTH-1:0]                ptag;
    } pte;
  } cfg_word_u;

endpackage

// File: verilog/dmmu_cfg_regs.sv
`timescale 1ns/1ps
/* APB slave with zero wait states. Slot writes and fences take effect on the
   access-phase edge, the VTAG register must be written before each slot write. */
module dmmu_cfg_regs
  import dmmu_pkg::*;
  (input  logic                      clk_i
   , input  logic                      reset_i

   , input  logic                      psel_i
   , input  logic                      penable_i
   , input  logic                      pwrite_i
   , input  logic [APB_ADDR_WIDTH-1:0] paddr_i
   , input  logic [APB_DATA_WIDTH-1:0] pwdata_i
   , output logic [APB_DATA_WIDTH-1:0] prdata_o
   , output logic                      pready_o
   , output logic                      pslverr_o

   , output logic [1:0]                priv_mode_o
   , output logic                      sum_o
   , output logic                      translation_en_o
   , output logic                      uncached_mode_o

   , output logic                      tlb_w_v_o
   , output logic [TLB_IDX_WIDTH-1:0]  tlb_w_idx_o
   , output logic [VTAG_WIDTH-1:0]     tlb_w_vtag_o
   , output cfg_word_u                 tlb_w_pte_o
   , output logic                      tlb_fence_o
   );

  cfg_word_u                 wdata;
  cfg_word_u                 rdata;
  logic [APB_ADDR_WIDTH-1:0] entry_offset;
  logic                      access;
  logic                      wr_access;
  logic                      sel_ctrl;
  logic                      sel_vtag;
  logic                      sel_fence;
  logic                      sel_entry;
  logic [VTAG_WIDTH-1:0]     vtag_r;

  assign wdata     = pwdata_i;
  assign access    = psel_i & penable_i;
  assign wr_access = access & pwrite_i;

  // Address decode
  assign entry_offset = paddr_i - APB_ADDR_ENTRY_BASE;
  assign sel_ctrl     = (paddr_i == APB_ADDR_CTRL);
  assign sel_vtag     = (paddr_i == APB_ADDR_VTAG);
  assign sel_fence    = (paddr_i == APB_ADDR_FENCE);
  assign sel_entry    = (paddr_i >= APB_ADDR_ENTRY_BASE)
                        && (entry_offset < APB_ENTRY_SPAN)
                        && (paddr_i[1:0] == 2'b00);

  assign pready_o  = 1'b1;
  assign pslverr_o = access & ~(sel_ctrl | sel_vtag | sel_fence | sel_entry);

  // Control register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      priv_mode_o      <= PRIV_U;
      sum_o            <= 1'b0;
      translation_en_o <= 1'b0;
      uncached_mode_o  <= 1'b0;
    end else if (wr_access && sel_ctrl) begin
      priv_mode_o      <= wdata.ctrl.priv_mode;
      sum_o            <= wdata.ctrl.sum;
      translation_en_o <= wdata.ctrl.translation_en;
      uncached_mode_o  <= wdata.ctrl.uncached_mode;
    end
  end

  // Staged tag for the next slot write
  always_ff @(posedge clk_i) begin
    if (wr_access && sel_vtag) begin
      vtag_r <= pwdata_i[VTAG_WIDTH-1:0];
    end
  end

  always_comb begin
    rdata                     = '0;
    rdata.ctrl.priv_mode      = priv_mode_o;
    rdata.ctrl.sum            = sum_o;
    rdata.ctrl.translation_en = translation_en_o;
    rdata.ctrl.uncached_mode  = uncached_mode_o;
  end

  assign prdata_o = sel_ctrl ? rdata : '0;

  // TLB strobes last exactly the access phase
  assign tlb_w_v_o    = wr_access & sel_entry;
  assign tlb_w_idx_o  = entry_offset[TLB_IDX_WIDTH+1:2];
  assign tlb_w_vtag_o = vtag_r;
  assign tlb_w_pte_o  = wdata;
  assign tlb_fence_o  = wr_access & sel_fence;

endmodule

// File: dtlb/dtlb_lookup.sv
`timescale 1ns/1ps
/* Fully associative DTLB and pipeline stage 1. Kill hides the stage 1 item from
   stage 2 in the same cycle, so a killed item never reaches the response. */
module dtlb_lookup
  import dmmu_pkg::*;
  (input  logic                     clk_i
   , input  logic                     reset_i
   , input  logic                     stall_i
   , input  logic                     kill_i

   , input  logic                     req_v_i
   , input  logic [VADDR_WIDTH-1:0]   req_vaddr_i
   , input  logic                     req_store_i

   , input  logic                     tlb_w_v_i
   , input  logic [TLB_IDX_WIDTH-1:0] tlb_w_idx_i
   , input  logic [VTAG_WIDTH-1:0]    tlb_w_vtag_i
   , input  cfg_word_u                tlb_w_pte_i
   , input  logic                     tlb_fence_i

   , output logic                     s1_v_o
   , output logic [VADDR_WIDTH-1:0]   s1_vaddr_o
   , output logic                     s1_store_o
   , output logic                     s1_hit_o
   , output cfg_word_u                s1_pte_o
   );

  logic [VTAG_WIDTH-1:0]    tag_r [TLB_ENTRIES];
  cfg_word_u                pte_r [TLB_ENTRIES];
  logic [TLB_ENTRIES-1:0]   valid_r;
  logic [TLB_ENTRIES-1:0]   match;
  logic [TLB_IDX_WIDTH-1:0] hit_idx;
  logic [VTAG_WIDTH-1:0]    req_vtag;
  logic                     s1_v_r;

  assign req_vtag = req_vaddr_i[VADDR_WIDTH-1:PAGE_OFFSET_WIDTH];

  // Valid bits, APB updates land even while the pipe stalls
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
    end else if (tlb_fence_i) begin
      valid_r <= '0;
    end else if (tlb_w_v_i) begin
      valid_r[tlb_w_idx_i] <= tlb_w_pte_i.pte.v;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tlb_w_v_i) begin
      tag_r[tlb_w_idx_i] <= tlb_w_vtag_i;
      pte_r[tlb_w_idx_i] <= tlb_w_pte_i;
    end
  end

  always_comb begin
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      match[i] = valid_r[i] && (tag_r[i] == req_vtag);
    end
  end

  // Lowest matching slot wins
  always_comb begin
    hit_idx = '0;
    for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
      if (match[i]) begin
        hit_idx = TLB_IDX_WIDTH'(i);
      end
    end
  end

  // Kill wins over holding during a stall
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v_r <= 1'b0;
    end else if (!stall_i) begin
      s1_v_r <= req_v_i;
    end else if (kill_i) begin
      s1_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i && req_v_i) begin
      s1_vaddr_o <= req_vaddr_i;
      s1_store_o <= req_store_i;
      s1_hit_o   <= |match;
      s1_pte_o   <= pte_r[hit_idx];
    end
  end

  assign s1_v_o = s1_v_r & ~kill_i;

endmodule

// File: verilog/dmmu_perm_check.sv
`timescale 1ns/1ps
/* Pipeline stage 2 with fault checks and the response register.
   A miss reports PTAG zero and no faults, control is sampled as the item leaves stage 1. */
module dmmu_perm_check
  import dmmu_pkg::*;
  (input  logic                   clk_i
   , input  logic                   reset_i
   , input  logic                   stall_i

   , input  logic                   s1_v_i
   , input  logic [VADDR_WIDTH-1:0] s1_vaddr_i
   , input  logic                   s1_store_i
   , input  logic                   s1_hit_i
   , input  cfg_word_u              s1_pte_i

   , input  logic [1:0]             priv_mode_i
   , input  logic                   sum_i
   , input  logic                   translation_en_i
   , input  logic                   uncached_mode_i

   , output logic                   resp_v_o
   , output logic [PADDR_WIDTH-1:0] resp_paddr_o
   , output logic                   resp_miss_o
   , output logic                   resp_page_fault_o
   , output logic                   resp_access_fault_o
   , output logic                   resp_uncached_o
   );

  logic [VTAG_WIDTH-1:0] vtag;
  logic [PTAG_WIDTH-1:0] ptag;
  logic                  miss;
  logic                  priv_fault;
  logic                  write_fault;
  logic                  page_fault;
  logic                  did_fault;
  logic                  mode_fault;
  logic                  access_fault;

  assign vtag = s1_vaddr_i[VADDR_WIDTH-1:PAGE_OFFSET_WIDTH];
  assign miss = translation_en_i & ~s1_hit_i;

  // Bypass when translation is off
  always_comb begin
    if (!translation_en_i) begin
      ptag = vtag;
    end else if (s1_hit_i) begin
      ptag = s1_pte_i.pte.ptag;
    end else begin
      ptag = '0;
    end
  end

  always_comb begin
    case (priv_mode_i)
      PRIV_U:  priv_fault = ~s1_pte_i.pte.u;
      PRIV_S:  priv_fault = ~sum_i & s1_pte_i.pte.u;
      PRIV_M:  priv_fault = 1'b0;
      default: priv_fault = 1'b0;
    endcase
  end

  // Stores need both W and D, no hardware dirty update
  assign write_fault = s1_store_i & (~s1_pte_i.pte.w | ~s1_pte_i.pte.d);
  assign page_fault  = translation_en_i & s1_hit_i & (priv_fault | write_fault);

  assign did_fault    = |ptag[PTAG_WIDTH-1 -: DID_WIDTH];
  assign mode_fault   = uncached_mode_i & ~ptag[UNCACHED_BIT];
  assign access_fault = ~miss & (did_fault | mode_fault);

  // Response register holds while the consumer stalls
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_v_o <= 1'b0;
    end else if (!stall_i) begin
      resp_v_o <= s1_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i && s1_v_i) begin
      resp_paddr_o        <= {ptag, s1_vaddr_i[PAGE_OFFSET_WIDTH-1:0]};
      resp_miss_o         <= miss;
      resp_page_fault_o   <= page_fault;
      resp_access_fault_o <= access_fault;
      resp_uncached_o     <= ptag[UNCACHED_BIT];
    end
  end

endmodule

// File: verilog/dmmu_top.sv
`timescale 1ns/1ps
/* Two-stage data address translation with APB configuration.
   TLB misses are only reported, entries are filled through APB. */
module dmmu_top
  import dmmu_pkg::*;
  (input  logic                      clk_i
   , input  logic                      reset_i

   , input  logic                      psel_i
   , input  logic                      penable_i
   , input  logic                      pwrite_i
   , input  logic [APB_ADDR_WIDTH-1:0] paddr_i
   , input  logic [APB_DATA_WIDTH-1:0] pwdata_i
   , output logic [APB_DATA_WIDTH-1:0] prdata_o
   , output logic                      pready_o
   , output logic                      pslverr_o

   , input  logic                      req_v_i
   , input  logic [VADDR_WIDTH-1:0]    req_vaddr_i
   , input  logic                      req_store_i
   , output logic                      req_ready_o
   , input  logic                      kill_i

   , output logic                      resp_v_o
   , output logic [PADDR_WIDTH-1:0]    resp_paddr_o
   , output logic                      resp_miss_o
   , output logic                      resp_page_fault_o
   , output logic                      resp_access_fault_o
   , output logic                      resp_uncached_o
   , input  logic                      resp_ready_i
   );

  logic [1:0]               priv_mode;
  logic                     sum;
  logic                     translation_en;
  logic                     uncached_mode;
  logic                     tlb_w_v;
  logic [TLB_IDX_WIDTH-1:0] tlb_w_idx;
  logic [VTAG_WIDTH-1:0]    tlb_w_vtag;
  cfg_word_u                tlb_w_pte;
  logic                     tlb_fence;
  logic                     s1_v;
  logic [VADDR_WIDTH-1:0]   s1_vaddr;
  logic                     s1_store;
  logic                     s1_hit;
  cfg_word_u                s1_pte;
  logic                     stall;

  // Both stages hold while a response waits
  assign stall       = resp_v_o & ~resp_ready_i;
  assign req_ready_o = ~stall;

  dmmu_cfg_regs i_dmmu_cfg_regs
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.psel_i(psel_i)
     ,.penable_i(penable_i)
     ,.pwrite_i(pwrite_i)
     ,.paddr_i(paddr_i)
     ,.pwdata_i(pwdata_i)
     ,.prdata_o(prdata_o)
     ,.pready_o(pready_o)
     ,.pslverr_o(pslverr_o)
     ,.priv_mode_o(priv_mode)
     ,.sum_o(sum)
     ,.translation_en_o(translation_en)
     ,.uncached_mode_o(uncached_mode)
     ,.tlb_w_v_o(tlb_w_v)
     ,.tlb_w_idx_o(tlb_w_idx)
     ,.tlb_w_vtag_o(tlb_w_vtag)
     ,.tlb_w_pte_o(tlb_w_pte)
     ,.tlb_fence_o(tlb_fence)
     );

  dtlb_lookup i_dtlb_lookup
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.stall_i(stall)
     ,.kill_i(kill_i)
     ,.req_v_i(req_v_i)
     ,.req_vaddr_i(req_vaddr_i)
     ,.req_store_i(req_store_i)
     ,.tlb_w_v_i(tlb_w_v)
     ,.tlb_w_idx_i(tlb_w_idx)
     ,.tlb_w_vtag_i(tlb_w_vtag)
     ,.tlb_w_pte_i(tlb_w_pte)
     ,.tlb_fence_i(tlb_fence)
     ,.s1_v_o(s1_v)
     ,.s1_vaddr_o(s1_vaddr)
     ,.s1_store_o(s1_store)
     ,.s1_hit_o(s1_hit)
     ,.s1_pte_o(s1_pte)
     );

  dmmu_perm_check i_dmmu_perm_check
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.stall_i(stall)
     ,.s1_v_i(s1_v)
     ,.s1_vaddr_i(s1_vaddr)
     ,.s1_store_i(s1_store)
     ,.s1_hit_i(s1_hit)
     ,.s1_pte_i(s1_pte)
     ,.priv_mode_i(priv_mode)
     ,.sum_i(sum)
     ,.translation_en_i(translation_en)
     ,.uncached_mode_i(uncached_mode)
     ,.resp_v_o(resp_v_o)
     ,.resp_paddr_o(resp_paddr_o)
     ,.resp_miss_o(resp_miss_o)
     ,.resp_page_fault_o(resp_page_fault_o)
     ,.resp_access_fault_o(resp_access_fault_o)
     ,.resp_uncached_o(resp_uncached_o)
     );

endmodule

// File: test/dmmu_tb.sv
`timescale 1ns/1ps
/* Reads test/dmmu_tests.txt relative to the working directory, so run from the project root.
   Responses are checked in order, killed requests expect none. */
module dmmu_tb
  import dmmu_pkg::*;
  ();

  logic                      clk;
  logic                      reset;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  logic [APB_ADDR_WIDTH-1:0] paddr;
  logic [APB_DATA_WIDTH-1:0] pwdata;
  logic [APB_DATA_WIDTH-1:0] prdata;
  logic                      pready;
  logic                      pslverr;
  logic                      req_v;
  logic [VADDR_WIDTH-1:0]    req_vaddr;
  logic                      req_store;
  logic                      req_ready;
  logic                      kill;
  logic                      resp_v;
  logic [PADDR_WIDTH-1:0]    resp_paddr;
  logic                      resp_miss;
  logic                      resp_page_fault;
  logic                      resp_access_fault;
  logic                      resp_uncached;
  logic                      resp_ready;

  // Expected response packed as paddr, miss, page fault, access fault and uncached
  logic [35:0] exp_q[$];
  logic [31:0] rng_state;
  logic        stall_mode;
  int          errors;
  int          checks;
  int          tests;
  int          tests_failed;
  int          cycles;
  int          cycle_limit;

  dmmu_top i_dmmu_top
    (.clk_i(clk)
     ,.reset_i(reset)
     ,.psel_i(psel)
     ,.penable_i(penable)
     ,.pwrite_i(pwrite)
     ,.paddr_i(paddr)
     ,.pwdata_i(pwdata)
     ,.prdata_o(prdata)
     ,.pready_o(pready)
     ,.pslverr_o(pslverr)
     ,.req_v_i(req_v)
     ,.req_vaddr_i(req_vaddr)
     ,.req_store_i(req_store)
     ,.req_ready_o(req_ready)
     ,.kill_i(kill)
     ,.resp_v_o(resp_v)
     ,.resp_paddr_o(resp_paddr)
     ,.resp_miss_o(resp_miss)
     ,.resp_page_fault_o(resp_page_fault)
     ,.resp_access_fault_o(resp_access_fault)
     ,.resp_uncached_o(resp_uncached)
     ,.resp_ready_i(resp_ready)
     );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic string trim_end(input string s);
    string t;
    t = s;
    while (t.len() > 0 && (t.getc(t.len() - 1) == "\n" || t.getc(t.len() - 1) == "\r"
                           || t.getc(t.len() - 1) == " ")) begin
      t = t.substr(0, t.len() - 2);
    end
    return t;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // All driving happens 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
    kill = 1'b0;
    rng_state = lcg_next(rng_state);
    resp_ready = stall_mode ? rng_state[31] : 1'b1;
  endtask

  task automatic apb_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] data, input logic exp_err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = APB_ADDR_WIDTH'(addr);
    pwdata  = write ? data : '0;
    next_cycle();
    penable = 1'b1;
    @(negedge clk);
    check_value("pready_o", 32'd1, 32'(pready));
    check_value("pslverr_o", 32'(exp_err), 32'(pslverr));
    if (!write) begin
      check_value("prdata_o", data, prdata);
    end
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // Kill goes high for the one cycle the item sits in stage 1
  task automatic send_request(input logic [31:0] vaddr, input logic store,
                              input logic kill_req, input logic [35:0] expected);
    req_v     = 1'b1;
    req_vaddr = vaddr;
    req_store = store;
    @(negedge clk);
    while (!req_ready) begin
      next_cycle();
      @(negedge clk);
    end
    next_cycle();
    req_v = 1'b0;
    kill  = kill_req;
    if (!kill_req) begin
      exp_q.push_back(expected);
    end
  endtask

  task automatic finish_test(input string name, input int err_base, input int check_base);
    while (exp_q.size() != 0) begin
      next_cycle();
    end
    stall_mode = 1'b0;
    // Room for a stray response to show up
    repeat (3) begin
      next_cycle();
    end
    tests++;
    if (errors == err_base) begin
      $display("Test %-16s ok, %0d checks", name, checks - check_base);
    end else begin
      tests_failed++;
      $display("Test %-16s failed, %0d errors", name, errors - err_base);
    end
  endtask

  // Consumed responses are compared in the low phase, where all are stable
  always @(negedge clk) begin
    logic [35:0] expected;
    if (!reset && resp_v && resp_ready) begin
      assert (exp_q.size() != 0) else begin
        $display("Response at %0t ns with paddr %h arrived with no request pending",
                 $time, resp_paddr);
        errors++;
      end
      if (exp_q.size() != 0) begin
        expected = exp_q.pop_front();
        check_value("resp_paddr_o", expected[35:4], resp_paddr);
        check_value("resp_miss_o", 32'(expected[3]), 32'(resp_miss));
        check_value("resp_page_fault_o", 32'(expected[2]), 32'(resp_page_fault));
        check_value("resp_access_fault_o", 32'(expected[1]), 32'(resp_access_fault));
        check_value("resp_uncached_o", 32'(expected[0]), 32'(resp_uncached));
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  initial begin
    string       lines[$];
    string       line;
    string       rest;
    byte         kind;
    int          fd;
    int          n;
    int          err_base;
    int          check_base;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_err;
    logic [31:0] q_vaddr;
    logic [31:0] q_store;
    logic [31:0] q_kill;
    logic [31:0] q_stall;
    logic [31:0] q_paddr;
    logic [31:0] q_miss;
    logic [31:0] q_pf;
    logic [31:0] q_af;
    logic [31:0] q_unc;

    reset      = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    req_v      = 1'b0;
    req_vaddr  = '0;
    req_store  = 1'b0;
    kill       = 1'b0;
    resp_ready = 1'b1;
    stall_mode = 1'b0;
    rng_state  = 32'ha2ab_2e5a;

    fd = $fopen("test/dmmu_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open test/dmmu_tests.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0) begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
    cycle_limit = 50 * lines.size();

    repeat (4) begin
      next_cycle();
    end
    reset      = 1'b0;
    err_base   = errors;
    check_base = checks;

    foreach (lines[i]) begin
      line = trim_end(lines[i]);
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      kind = line.getc(0);
      rest = line.substr(2, line.len() - 1);
      case (kind)
        "W", "R": begin
          n = $sscanf(rest, "%h %h %h", f_addr, f_data, f_err);
          if (n == 3) begin
            apb_access(kind == "W", f_addr, f_data, f_err[0]);
          end
        end
        "Q": begin
          n = $sscanf(rest, "%h %h %h %h %h %h %h %h %h", q_vaddr, q_store, q_kill,
                      q_stall, q_paddr, q_miss, q_pf, q_af, q_unc);
          if (n == 9) begin
            stall_mode = q_stall[0];
            send_request(q_vaddr, q_store[0], q_kill[0],
                         {q_paddr, q_miss[0], q_pf[0], q_af[0], q_unc[0]});
          end
        end
        "E": begin
          n = 1;
          finish_test(rest, err_base, check_base);
          err_base   = errors;
          check_base = checks;
        end
        default: n = 0;
      endcase
      assert (n != 0 && (kind != "Q" || n == 9) && (kind == "Q" || kind == "E" || n == 3))
      else begin
        $display("Line %0d of the tests file could not be parsed", i + 1);
        errors++;
      end
    end

    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             tests, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: test/dmmu_tests.txt
# W addr data err | R addr rdata err | E test_name   (numbers in hex)
# Q vaddr store kill stall paddr miss page_fault access_fault uncached
R 00 00000000 0
Q 00123456 0 0 0 00123456 0 0 0 0
Q 4000A010 1 0 0 4000A010 0 0 1 0
Q 2ABCD123 0 0 0 2ABCD123 0 0 0 1
W 00 00000010 0
R 00 00000010 0
Q 00123456 0 0 0 00123456 0 0 1 0
Q 2ABCD123 0 0 0 2ABCD123 0 0 0 1
W 0C 00000000 1
R 42 00000000 1
E translation_off
W 00 00000008 0
W 04 00000012 0
W 40 00F00345 0
W 04 000ABCDE 0
W 5C 00F20077 0
W 04 00000077 0
W 58 00F00666 0
W 4C 00F00333 0
R 04 00000000 0
Q 00012ABC 0 0 0 00345ABC 0 0 0 0
Q ABCDE800 1 0 0 20077800 0 0 0 1
Q 00077010 0 0 0 00333010 0 0 0 0
Q 00056123 0 0 0 00000123 1 0 0 0
W 08 00000000 0
Q 00012ABC 0 0 0 00000ABC 1 0 0 0
Q ABCDE800 0 0 0 00000800 1 0 0 0
E tlb_fill_hit
W 04 00010000 0
W 40 00F00100 0
W 04 00010001 0
W 44 00E00101 0
W 04 00010003 0
W 48 00B00103 0
W 04 00010004 0
W 4C 00800104 0
Q 10000000 1 0 0 00100000 0 0 0 0
Q 10001000 0 0 0 00101000 0 1 0 0
Q 10003000 1 0 0 00103000 0 1 0 0
W 00 00000009 0
Q 10000000 0 0 0 00100000 0 1 0 0
Q 10001000 1 0 0 00101000 0 0 0 0
Q 10004000 1 0 0 00104000 0 1 0 0
W 00 0000000D 0
Q 10000000 1 0 0 00100000 0 0 0 0
W 00 0000000B 0
Q 10001000 0 0 0 00101000 0 0 0 0
Q 10004000 1 0 0 00104000 0 1 0 0
E page_faults
W 04 00020000 0
W 54 00F80010 0
W 04 00020001 0
W 58 00F20400 0
Q 20000123 0 0 0 80010123 0 0 1 0
Q 20001123 0 0 0 20400123 0 0 0 1
W 00 0000001B 0
Q 10000123 0 0 0 00100123 0 0 1 0
Q 20001123 0 0 0 20400123 0 0 0 1
Q 30000456 0 0 0 00000456 1 0 0 0
W 00 0000000B 0
E access_faults
Q 10000010 0 0 1 00100010 0 0 0 0
Q 10001020 1 0 1 00101020 0 0 0 0
Q 10003030 1 0 1 00103030 0 1 0 0
Q 20001040 0 0 1 20400040 0 0 0 1
Q 20000050 0 0 1 80010050 0 0 1 0
Q 30000060 0 0 1 00000060 1 0 0 0
Q 10004070 0 0 1 00104070 0 0 0 0
Q 100000A0 1 0 1 001000A0 0 0 0 0
E back_pressure
Q 10000100 0 0 0 00100100 0 0 0 0
Q 10001200 0 1 0 00000000 0 0 0 0
Q 10003300 0 0 0 00103300 0 0 0 0
Q 20000400 0 1 0 00000000 0 0 0 0
Q 20001500 0 1 0 00000000 0 0 0 0
Q 10004600 1 0 0 00104600 0 1 0 0
Q 10000700 0 1 1 00000000 0 0 0 0
Q 10001800 0 0 1 00101800 0 0 0 0
E kill

// File: dmmu.f
common/dmmu_pkg.sv
verilog/dmmu_cfg_regs.sv
dtlb/dtlb_lookup.sv
verilog/dmmu_perm_check.sv
verilog/dmmu_top.sv
test/dmmu_tb.sv

// File: Makefile
# Verilator build and run for the DMMU testbench

SIM  := obj_dir/Vdmmu_tb
SRCS := $(shell cat dmmu.f)

all: run

# Rebuilt only when a source or the file list changes
$(SIM): dmmu.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module dmmu_tb -f dmmu.f -o Vdmmu_tb

# The log decides pass or fail
run: $(SIM) test/dmmu_tests.txt
	./$(SIM) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
